// ==== tb.f ====
src/exec_pkg.sv
src/alu.sv
src/alu_control.sv
src/instr_decode.sv
src/exec_stage.sv
src/exec_unit.sv
bench/exec_unit_tb.sv

// ==== bench/exec_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit_tb;
   import exec_pkg::*;

   localparam int clk_period = 8;
   localparam int n_random   = 400;
   localparam int n_directed = 60;    // Directed, stall and bubble cycles
   localparam int n_tests    = n_random + n_directed;

   logic        clk;
   logic        reset;
   logic        we;
   instr_word_t instr;
   word_t       src1;
   word_t       reg2;
   addr_t       old_pc;
   ex_mem_t     ex_mem;

   ex_mem_t     expected;    // Model of the pipeline register
   ex_mem_t     held;
   logic [31:0] rng_state;

   exec_unit UUT (
      .clk    (clk),
      .reset  (reset),
      .we     (we),
      .instr  (instr),
      .src1   (src1),
      .reg2   (reg2),
      .old_pc (old_pc),
      .ex_mem (ex_mem)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Limits show up more often than plain random draws would give them
   function word_t random_operand();
      logic [31:0] r;
      r = next_random();
      case (r[2:0])
         3'd0:    return 32'h7fffffff;
         3'd1:    return 32'h80000000;
         3'd2:    return 32'hffffffff;
         default: return next_random();
      endcase
   endfunction

   function automatic logic [5:0] pick_opcode(input int idx);
      case (idx)
         0:       return op_rtype;
         1:       return op_addi;
         2:       return op_addiu;
         3:       return op_slti;
         4:       return op_sltiu;
         5:       return op_andi;
         6:       return op_ori;
         7:       return op_xori;
         8:       return op_lui;
         9:       return op_lw;
         10:      return op_sw;
         11:      return op_beq;
         default: return op_bne;
      endcase
   endfunction

   function automatic logic [5:0] pick_funct(input int idx);
      case (idx)
         0:       return fn_add;
         1:       return fn_addu;
         2:       return fn_sub;
         3:       return fn_subu;
         4:       return fn_and;
         5:       return fn_or;
         6:       return fn_xor;
         7:       return fn_nor;
         8:       return fn_slt;
         9:       return fn_sltu;
         10:      return fn_sll;
         11:      return fn_srl;
         default: return fn_sra;
      endcase
   endfunction

   // Exact sum or difference checked against the 32-bit signed range
   function automatic logic sum_out_of_range(input word_t x, input word_t y, input logic negate);
      longint lhs;
      longint rhs;
      longint s;
      lhs = $signed(x);
      rhs = $signed(y);
      s   = negate ? lhs - rhs : lhs + rhs;
      return (s > 64'sd2147483647) || (s < -64'sd2147483648);
   endfunction

   function automatic ex_mem_t ref_exec(input instr_word_t in, input word_t a, input word_t b,
                                        input addr_t pc);
      ex_mem_t r;
      word_t   imm_s;
      word_t   imm_z;
      word_t   res;
      logic    ovf;
      r            = '0;
      ovf          = 1'b0;
      imm_s        = {{16{in.i.imm[15]}}, in.i.imm};
      imm_z        = {16'h0000, in.i.imm};
      r.data_store = b;
      r.pc_branch  = pc + (imm_s << 2);   // Word offset from the low half
      if (in.r.opcode == op_rtype) begin
         r.dst_reg  = in.r.rd;
         r.regwrite = 1'b1;
         case (in.r.funct)
            fn_add: begin
               res = a + b;
               ovf = sum_out_of_range(a, b, 1'b0);
            end
            fn_sub: begin
               res = a - b;
               ovf = sum_out_of_range(a, b, 1'b1);
            end
            fn_addu: res = a + b;
            fn_subu: res = a - b;
            fn_and:  res = a & b;
            fn_or:   res = a | b;
            fn_xor:  res = a ^ b;
            fn_nor:  res = ~(a | b);
            fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
            fn_sll:  res = b << in.r.shamt;
            fn_srl:  res = b >> in.r.shamt;
            fn_sra:  res = $signed(b) >>> in.r.shamt;
            default: begin
               r.regwrite = 1'b0;   // Unknown funct falls back to add
               res        = a + b;
               ovf        = sum_out_of_range(a, b, 1'b0);
            end
         endcase
      end else begin
         r.dst_reg  = in.i.rt;
         r.regwrite = 1'b1;
         case (in.i.opcode)
            op_addi: begin
               res = a + imm_s;
               ovf = sum_out_of_range(a, imm_s, 1'b0);
            end
            op_addiu: res = a + imm_s;
            op_slti:  res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            op_sltiu: res = (a < imm_s) ? 32'd1 : 32'd0;
            op_andi:  res = a & imm_z;
            op_ori:   res = a | imm_z;
            op_xori:  res = a ^ imm_z;
            op_lui:   res = {in.i.imm, 16'h0000};
            op_lw: begin
               res        = a + imm_s;
               r.do_read  = 1'b1;
               r.memtoreg = 1'b1;
            end
            op_sw: begin
               res        = a + imm_s;
               r.regwrite = 1'b0;
            end
            op_beq, op_bne: begin
               res         = a - b;   // Zero flag decides the branch
               ovf         = sum_out_of_range(a, b, 1'b1);
               r.regwrite  = 1'b0;
               r.is_branch = 1'b1;
            end
            default: begin
               res        = a + imm_s;
               r.regwrite = 1'b0;
               ovf        = sum_out_of_range(a, imm_s, 1'b0);
            end
         endcase
      end
      r.alu_result = res;
      r.zero       = (res == '0);
      r.overflow   = ovf;
      return r;
   endfunction

   function automatic instr_word_t build_rtype(input logic [5:0] fn, input reg_idx_t rd,
                                               input logic [4:0] sh);
      instr_word_t w;
      w = {op_rtype, 5'd1, 5'd2, rd, sh, fn};
      return w;
   endfunction

   function automatic instr_word_t build_itype(input logic [5:0] op, input reg_idx_t rt,
                                               input logic [15:0] imm);
      instr_word_t w;
      w = {op, 5'd3, rt, imm};
      return w;
   endfunction

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1, "Simulation stopped on the first failure");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns: %s expected %b, got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic compare_ex_mem(input ex_mem_t exp, input ex_mem_t act);
      check_flag("ex_mem.regwrite", exp.regwrite, act.regwrite);
      check_flag("ex_mem.zero", exp.zero, act.zero);
      check_flag("ex_mem.overflow", exp.overflow, act.overflow);
      check_word("ex_mem.alu_result", exp.alu_result, act.alu_result);
      check_word("ex_mem.data_store", exp.data_store, act.data_store);
      check_word("ex_mem.pc_branch", exp.pc_branch, act.pc_branch);
      check_flag("ex_mem.do_read", exp.do_read, act.do_read);
      check_flag("ex_mem.memtoreg", exp.memtoreg, act.memtoreg);
      check_flag("ex_mem.is_branch", exp.is_branch, act.is_branch);
      check_reg("ex_mem.dst_reg", exp.dst_reg, act.dst_reg);
   endtask

   task automatic drive_inputs(input instr_word_t in, input word_t a, input word_t b,
                               input addr_t pc, input logic adv);
      @(negedge clk);
      instr  = in;
      src1   = a;
      reg2   = b;
      old_pc = pc;
      we     = adv;
   endtask

   // Bubble must not write, read or branch
   task automatic check_bubble();
      @(posedge clk);
      #2;
      check_flag("ex_mem.regwrite", 1'b0, ex_mem.regwrite);
      check_flag("ex_mem.do_read", 1'b0, ex_mem.do_read);
      check_flag("ex_mem.is_branch", 1'b0, ex_mem.is_branch);
   endtask

   always @(posedge clk) begin
      if (reset) begin
         expected <= '0;
      end else if (we) begin
         expected <= ref_exec(instr, src1, reg2, old_pc);
      end
   end

   initial begin
      @(posedge clk);
      forever begin
         #2;   // Register settled, inputs not yet changed
         compare_ex_mem(expected, ex_mem);
         @(posedge clk);
      end
   end

   initial begin
      #((n_tests + 20) * clk_period * 2);
      $display("Timeout: the test sequence did not finish in the expected time");
      abort_run();
   end

   initial begin
      instr_word_t w;
      word_t       a;
      word_t       b;
      rng_state = 32'd94646;
      reset     = 1'b1;
      we        = 1'b0;
      instr     = '0;
      src1      = '0;
      reg2      = '0;
      old_pc    = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      repeat (3) begin   // Changing inputs while we stays low
         w = next_random();
         drive_inputs(w, next_random(), next_random(), next_random(), 1'b0);
      end
      @(posedge clk);
      #2;
      check_flag("ex_mem cleared after reset", 1'b1, ex_mem == '0);

      // R-type at the signed limits
      drive_inputs(build_rtype(fn_add, 5'd4, 5'd0), 32'h7fffffff, 32'h00000001, 32'h1000, 1'b1);
      drive_inputs(build_rtype(fn_add, 5'd5, 5'd0), 32'h80000000, 32'hffffffff, 32'h1004, 1'b1);
      drive_inputs(build_rtype(fn_addu, 5'd6, 5'd0), 32'h7fffffff, 32'h00000001, 32'h1008, 1'b1);
      drive_inputs(build_rtype(fn_sub, 5'd7, 5'd0), 32'h80000000, 32'h00000001, 32'h100c, 1'b1);
      drive_inputs(build_rtype(fn_sub, 5'd8, 5'd0), 32'h7fffffff, 32'hffffffff, 32'h1010, 1'b1);
      drive_inputs(build_rtype(fn_subu, 5'd9, 5'd0), 32'h80000000, 32'h00000001, 32'h1014, 1'b1);
      drive_inputs(build_rtype(fn_slt, 5'd10, 5'd0), 32'hffffffff, 32'h00000001, 32'h1018, 1'b1);
      drive_inputs(build_rtype(fn_sltu, 5'd11, 5'd0), 32'hffffffff, 32'h00000001, 32'h101c, 1'b1);
      drive_inputs(build_rtype(fn_sll, 5'd12, 5'd4), 32'h0, 32'h80000001, 32'h1020, 1'b1);
      drive_inputs(build_rtype(fn_srl, 5'd13, 5'd31), 32'h0, 32'h80000001, 32'h1024, 1'b1);
      drive_inputs(build_rtype(fn_sra, 5'd14, 5'd4), 32'h0, 32'h80000001, 32'h1028, 1'b1);
      drive_inputs(build_rtype(fn_nor, 5'd15, 5'd0), 32'h0f0f0000, 32'h000000f0, 32'h102c, 1'b1);
      drive_inputs(build_rtype(fn_and, 5'd16, 5'd0), 32'hff00ff00, 32'h0ff00ff0, 32'h1030, 1'b1);

      // I-type extension rules and lui
      drive_inputs(build_itype(op_addi, 5'd17, 16'h0001), 32'h7fffffff, 32'h0, 32'h2000, 1'b1);
      drive_inputs(build_itype(op_addiu, 5'd18, 16'hffff), 32'h00000005, 32'h0, 32'h2004, 1'b1);
      drive_inputs(build_itype(op_slti, 5'd19, 16'hfff0), 32'hffffffe0, 32'h0, 32'h2008, 1'b1);
      drive_inputs(build_itype(op_sltiu, 5'd20, 16'hffff), 32'h7fffffff, 32'h0, 32'h200c, 1'b1);
      drive_inputs(build_itype(op_andi, 5'd21, 16'h8001), 32'hffffffff, 32'h0, 32'h2010, 1'b1);
      drive_inputs(build_itype(op_ori, 5'd22, 16'h8000), 32'h00000001, 32'h0, 32'h2014, 1'b1);
      drive_inputs(build_itype(op_xori, 5'd23, 16'hffff), 32'hffff0f0f, 32'h0, 32'h2018, 1'b1);
      drive_inputs(build_itype(op_lui, 5'd24, 16'habcd), 32'h12345678, 32'h0, 32'h201c, 1'b1);

      // Loads, stores and branches
      drive_inputs(build_itype(op_lw, 5'd25, 16'hfffc), 32'h00001000, 32'h55aa55aa, 32'h3000, 1'b1);
      drive_inputs(build_itype(op_sw, 5'd26, 16'h0010), 32'h00001000, 32'hcafef00d, 32'h3004, 1'b1);
      drive_inputs(build_itype(op_beq, 5'd2, 16'hfff0), 32'h00000042, 32'h00000042, 32'h3008, 1'b1);
      drive_inputs(build_itype(op_beq, 5'd2, 16'h0020), 32'h00000042, 32'h00000043, 32'h300c, 1'b1);
      drive_inputs(build_itype(op_bne, 5'd2, 16'h8000), 32'h80000000, 32'h80000000, 32'h3010, 1'b1);
      drive_inputs(build_itype(op_bne, 5'd2, 16'h7fff), 32'h00000000, 32'hffffffff, 32'h3014, 1'b1);

      // Stall with changing inputs
      drive_inputs(build_rtype(fn_xor, 5'd27, 5'd0), 32'hdeadbeef, 32'h12345678, 32'h4000, 1'b1);
      @(posedge clk);
      #2;
      held = expected;
      repeat (6) begin
         w = next_random();
         drive_inputs(w, next_random(), next_random(), next_random(), 1'b0);
      end
      @(posedge clk);
      #2;
      compare_ex_mem(held, ex_mem);

      // Opcodes and function codes outside the tables
      drive_inputs(build_itype(6'h3f, 5'd28, 16'h1234), 32'h7fffffff, 32'h1, 32'h5000, 1'b1);
      check_bubble();
      drive_inputs(build_itype(6'h02, 5'd29, 16'h0040), 32'h00000010, 32'h2, 32'h5004, 1'b1);
      check_bubble();
      drive_inputs(build_rtype(6'h3f, 5'd30, 5'd3), 32'h80000000, 32'h80000000, 32'h5008, 1'b1);
      check_bubble();

      for (int k = 0; k < n_random; k++) begin
         w          = next_random();
         w.r.opcode = pick_opcode(next_random() % 13);
         if (w.r.opcode == op_rtype) begin
            w.r.funct = pick_funct(next_random() % 13);
         end
         a = random_operand();
         b = random_operand();
         if ((next_random() % 4) == 0) begin
            b = a;   // Equal operands for beq and bne
         end
         drive_inputs(w, a, b, next_random(), (next_random() % 4) != 0);
      end

      @(posedge clk);
      @(posedge clk);
      #4;
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        we,
   input  wire exec_pkg::instr_word_t instr,
   input  wire exec_pkg::word_t       src1,     // rs value
   input  wire exec_pkg::word_t       reg2,     // rt value
   input  wire exec_pkg::addr_t       old_pc,
   output exec_pkg::ex_mem_t          ex_mem
);
   import exec_pkg::*;

   ctrl_t ctrl;   // Decoded control into the stage

   instr_decode u_decode (
      .instr (instr),
      .ctrl  (ctrl)
   );

   exec_stage u_exec (
      .clk    (clk),
      .reset  (reset),
      .we     (we),
      .ctrl   (ctrl),
      .src1   (src1),
      .reg2   (reg2),
      .old_pc (old_pc),
      .ex_mem (ex_mem)
   );

endmodule

`default_nettype wire

// ==== src/exec_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
   input  wire                    clk,
   input  wire                    reset,
   input  wire                    we,       // Advance the stage, low stalls
   input  wire exec_pkg::ctrl_t   ctrl,
   input  wire exec_pkg::word_t   src1,
   input  wire exec_pkg::word_t   reg2,
   input  wire exec_pkg::addr_t   old_pc,   // Address of the next instruction
   output exec_pkg::ex_mem_t      ex_mem
);
   import exec_pkg::*;

   alu_op_e aluop;
   word_t   src2;
   word_t   alu_out;
   logic    alu_zero;
   logic    alu_overflow;
   addr_t   branch_off;
   addr_t   pc_target;
   ex_mem_t ex_mem_next;

   assign src2 = ctrl.alusrc ? reg2 : ctrl.imm;

   // Word offset from the low half of the immediate
   assign branch_off = {{(addr_size-18){ctrl.imm[15]}}, ctrl.imm[15:0], 2'b00};
   assign pc_target  = old_pc + branch_off;

   alu_control u_alu_control (
      .opcode    (ctrl.opcode),
      .funct     (ctrl.funct),
      .aluop_out (aluop)
   );

   alu u_alu (
      .aluop    (aluop),
      .src1     (src1),
      .src2     (src2),
      .shamt    (ctrl.shamt),
      .out      (alu_out),
      .zero     (alu_zero),
      .overflow (alu_overflow)
   );

   always_comb begin
      ex_mem_next.regwrite   = ctrl.regwrite;
      ex_mem_next.zero       = alu_zero;
      ex_mem_next.overflow   = alu_overflow;
      ex_mem_next.alu_result = alu_out;
      ex_mem_next.data_store = reg2;   // Store data for sw
      ex_mem_next.pc_branch  = pc_target;
      ex_mem_next.do_read    = ctrl.do_read;
      ex_mem_next.memtoreg   = ctrl.memtoreg;
      ex_mem_next.is_branch  = ctrl.is_branch;
      ex_mem_next.dst_reg    = ctrl.dst_reg;
   end

   // Execute/memory pipeline register
   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem <= '0;
      end else if (we) begin
         ex_mem <= ex_mem_next;
      end
   end

   // A stall freezes the whole register
   hold_on_stall: assert property (@(posedge clk) disable iff (reset)
      !we |=> $stable(ex_mem))
   else $error("exec_stage: ex_mem changed while we was low");

   // No write, read or branch leaks out right after reset
   quiet_after_reset: assert property (@(posedge clk)
      reset |=> !(ex_mem.regwrite || ex_mem.do_read || ex_mem.memtoreg || ex_mem.is_branch))
   else $error("exec_stage: control bits active after reset");

endmodule

`default_nettype wire

// ==== src/instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
   input  wire exec_pkg::instr_word_t instr,
   output exec_pkg::ctrl_t            ctrl
);
   import exec_pkg::*;

   logic is_rtype;
   logic funct_ok;

   assign is_rtype = (instr.r.opcode == op_rtype);

   // Function codes the ALU understands
   always_comb begin
      case (instr.r.funct)
         fn_add, fn_addu, fn_sub, fn_subu,
         fn_and, fn_or, fn_xor, fn_nor,
         fn_slt, fn_sltu,
         fn_sll, fn_srl, fn_sra: funct_ok = 1'b1;
         default:                funct_ok = 1'b0;
      endcase
   end

   always_comb begin
      ctrl        = '0;
      ctrl.opcode = instr.i.opcode;   // Same bits in both views

      if (is_rtype) begin
         ctrl.regwrite = funct_ok;    // Unknown funct writes nothing
         ctrl.alusrc   = 1'b1;
         ctrl.dst_reg  = instr.r.rd;
         ctrl.funct    = instr.r.funct;
         ctrl.shamt    = instr.r.shamt;
         // Low half of the word, kept sign-extended for the branch adder
         ctrl.imm      = {{16{instr.r.rd[4]}}, instr.r.rd, instr.r.shamt, instr.r.funct};
      end else begin
         ctrl.dst_reg = instr.i.rt;
         ctrl.imm     = {{16{instr.i.imm[15]}}, instr.i.imm};   // Sign-extend by default

         case (instr.i.opcode)
            op_addi, op_addiu, op_slti, op_sltiu: begin
               ctrl.regwrite = 1'b1;
            end
            op_andi, op_ori, op_xori: begin
               ctrl.regwrite = 1'b1;
               ctrl.imm      = {16'h0000, instr.i.imm};   // Logic ops zero-extend
            end
            op_lui: begin
               ctrl.regwrite = 1'b1;
               ctrl.imm      = {16'h0000, instr.i.imm};   // ALU moves it to the upper half
            end
            op_lw: begin
               ctrl.regwrite = 1'b1;
               ctrl.do_read  = 1'b1;
               ctrl.memtoreg = 1'b1;
            end
            op_sw: begin
               ctrl.regwrite = 1'b0;   // Address only, rt is the store data
            end
            op_beq, op_bne: begin
               // Compare rs against rt, the offset goes to the branch adder
               ctrl.is_branch = 1'b1;
               ctrl.alusrc    = 1'b1;
            end
            default: begin
               ctrl.regwrite = 1'b0;   // Unknown opcode behaves as a bubble
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/alu_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_control (
   input  wire [5:0]        opcode,
   input  wire [5:0]        funct,
   output exec_pkg::alu_op_e aluop_out
);
   import exec_pkg::*;

   always_comb begin
      aluop_out = alu_add;   // Fallback for unknown codes

      if (opcode == op_rtype) begin
         case (funct)
            fn_add:  aluop_out = alu_add;
            fn_addu: aluop_out = alu_addu;
            fn_sub:  aluop_out = alu_sub;
            fn_subu: aluop_out = alu_subu;
            fn_and:  aluop_out = alu_and;
            fn_or:   aluop_out = alu_or;
            fn_xor:  aluop_out = alu_xor;
            fn_nor:  aluop_out = alu_nor;
            fn_slt:  aluop_out = alu_slt;
            fn_sltu: aluop_out = alu_sltu;
            fn_sll:  aluop_out = alu_sll;
            fn_srl:  aluop_out = alu_srl;
            fn_sra:  aluop_out = alu_sra;
            default: aluop_out = alu_add;
         endcase
      end else begin
         case (opcode)
            op_addi:        aluop_out = alu_add;    // Signed, may overflow
            op_addiu:       aluop_out = alu_addu;
            op_slti:        aluop_out = alu_slt;
            op_sltiu:       aluop_out = alu_sltu;
            op_andi:        aluop_out = alu_and;
            op_ori:         aluop_out = alu_or;
            op_xori:        aluop_out = alu_xor;
            op_lui:         aluop_out = alu_lui;
            op_lw, op_sw:   aluop_out = alu_addu;   // Address add never flags
            op_beq, op_bne: aluop_out = alu_sub;    // Memory stage tests zero
            default:        aluop_out = alu_add;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
   input  var  exec_pkg::alu_op_e aluop,
   input  wire exec_pkg::word_t   src1,
   input  wire exec_pkg::word_t   src2,
   input  wire [4:0]              shamt,
   output exec_pkg::word_t        out,
   output logic                   zero,
   output logic                   overflow
);
   import exec_pkg::*;

   word_t sum;
   word_t diff;
   logic  sum_ovf;
   logic  diff_ovf;
   logic  lt_signed;
   logic  lt_unsigned;

   assign sum  = src1 + src2;
   assign diff = src1 - src2;

   // Same-sign inputs with a flipped result sign
   assign sum_ovf  = (src1[reg_size-1] == src2[reg_size-1]) &&
                     (sum[reg_size-1] != src1[reg_size-1]);
   // Opposite-sign inputs with the result taking the subtrahend's sign
   assign diff_ovf = (src1[reg_size-1] != src2[reg_size-1]) &&
                     (diff[reg_size-1] != src1[reg_size-1]);

   assign lt_signed   = ($signed(src1) < $signed(src2));
   assign lt_unsigned = (src1 < src2);

   always_comb begin
      case (aluop)
         alu_add,
         alu_addu: out = sum;
         alu_sub,
         alu_subu: out = diff;
         alu_and:  out = src1 & src2;
         alu_or:   out = src1 | src2;
         alu_xor:  out = src1 ^ src2;
         alu_nor:  out = ~(src1 | src2);
         alu_slt:  out = {{(reg_size-1){1'b0}}, lt_signed};
         alu_sltu: out = {{(reg_size-1){1'b0}}, lt_unsigned};
         alu_sll:  out = src2 << shamt;             // Shifts act on rt
         alu_srl:  out = src2 >> shamt;
         alu_sra:  out = word_t'($signed(src2) >>> shamt);
         alu_lui:  out = src2 << 16;
         default:  out = sum;
      endcase
   end

   assign zero = (out == '0);

   always_comb begin
      case (aluop)
         alu_add: overflow = sum_ovf;
         alu_sub: overflow = diff_ovf;
         default: overflow = 1'b0;   // Unsigned and logic ops never trap
      endcase
   end

endmodule

`default_nettype wire

// ==== src/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

   localparam int reg_size  = 32;   // Data word width
   localparam int addr_size = 32;   // PC width
   localparam int reg_addr  = 5;    // Register index width

   typedef logic [reg_size-1:0]  word_t;
   typedef logic [addr_size-1:0] addr_t;
   typedef logic [reg_addr-1:0]  reg_idx_t;

   // MIPS primary opcodes
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_beq   = 6'h04;
   localparam logic [5:0] op_bne   = 6'h05;
   localparam logic [5:0] op_addi  = 6'h08;
   localparam logic [5:0] op_addiu = 6'h09;
   localparam logic [5:0] op_slti  = 6'h0a;
   localparam logic [5:0] op_sltiu = 6'h0b;
   localparam logic [5:0] op_andi  = 6'h0c;
   localparam logic [5:0] op_ori   = 6'h0d;
   localparam logic [5:0] op_xori  = 6'h0e;
   localparam logic [5:0] op_lui   = 6'h0f;
   localparam logic [5:0] op_lw    = 6'h23;
   localparam logic [5:0] op_sw    = 6'h2b;

   // R-type function codes
   localparam logic [5:0] fn_sll  = 6'h00;
   localparam logic [5:0] fn_srl  = 6'h02;
   localparam logic [5:0] fn_sra  = 6'h03;
   localparam logic [5:0] fn_add  = 6'h20;
   localparam logic [5:0] fn_addu = 6'h21;
   localparam logic [5:0] fn_sub  = 6'h22;
   localparam logic [5:0] fn_subu = 6'h23;
   localparam logic [5:0] fn_and  = 6'h24;
   localparam logic [5:0] fn_or   = 6'h25;
   localparam logic [5:0] fn_xor  = 6'h26;
   localparam logic [5:0] fn_nor  = 6'h27;
   localparam logic [5:0] fn_slt  = 6'h2a;
   localparam logic [5:0] fn_sltu = 6'h2b;

   typedef enum logic [4:0] {
      alu_add, alu_addu, alu_sub, alu_subu,
      alu_and, alu_or, alu_xor, alu_nor,
      alu_slt, alu_sltu,
      alu_sll, alu_srl, alu_sra,
      alu_lui
   } alu_op_e;

   typedef struct packed {
      logic [5:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_fields_t;

   typedef struct packed {
      logic [5:0]  opcode;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;
   } i_fields_t;

   typedef union packed {
      r_fields_t r;
      i_fields_t i;
   } instr_word_t;

   typedef struct packed {
      logic       regwrite;
      logic       alusrc;      // 1 selects reg2, 0 the immediate
      logic       do_read;
      logic       memtoreg;
      logic       is_branch;
      reg_idx_t   dst_reg;
      word_t      imm;
      logic [5:0] opcode;
      logic [5:0] funct;
      logic [4:0] shamt;
   } ctrl_t;

   typedef struct packed {
      logic     regwrite;
      logic     zero;
      logic     overflow;
      word_t    alu_result;
      word_t    data_store;
      addr_t    pc_branch;
      logic     do_read;
      logic     memtoreg;
      logic     is_branch;
      reg_idx_t dst_reg;
   } ex_mem_t;

endpackage

`default_nettype wire
